// File: logic/keypad_settings.svh
/*
 * Keypad controller settings
 * Scan and debounce timing, event buffer depth and bus address width
 */
`ifndef KEYPAD_SETTINGS_SVH
`define KEYPAD_SETTINGS_SVH

// Clock cycles each row stays driven low while scanning
`define KEYPAD_SCAN_DWELL 16

// Cycles a press or release must stay stable
`define KEYPAD_DEBOUNCE_CYCLES 64

`define KEYPAD_FIFO_DEPTH 4 // Key events buffered

`define KEYPAD_AXI_ADDR_W 4 // Byte address, three registers

`endif

// File: logic/keypad_pkg.sv
/*
 * Keypad types shared by the scanner, timer, event buffer and registers
 */
package keypad_pkg;

    typedef enum logic [2:0] {
        SCAN,
        DEBOUNCE,
        HELD,
        RELEASE,
        OFF
    } scan_state_e;

    // Period loaded into the scan timer
    typedef enum logic {
        T_DWELL,
        T_DEBOUNCE
    } timer_mode_e;

    typedef struct packed {
        logic [3:0] code; // Hex value of the key
        logic [1:0] row;
        logic [1:0] col;
    } key_event_t;

endpackage

// File: logic/axil_pkg.sv
/*
 * AXI4-Lite bus types and the register map of the keypad controller
 */
`include "keypad_settings.svh"

package axil_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    typedef enum logic [`KEYPAD_AXI_ADDR_W-1:0] {
        REG_STATUS = 'h0,
        REG_DATA   = 'h4,
        REG_CTRL   = 'h8
    } reg_addr_e;

    typedef struct packed {
        logic [`KEYPAD_AXI_ADDR_W-1:0] awaddr;
        logic                          awvalid;
        logic [31:0]                   wdata;
        logic                          wvalid;
        logic                          bready;
        logic [`KEYPAD_AXI_ADDR_W-1:0] araddr;
        logic                          arvalid;
        logic                          rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        axil_resp_e  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        axil_resp_e  rresp;
        logic        rvalid;
    } axil_rsp_t;

endpackage

// File: logic/scan_timer.sv
/*
 * Scan timer, counts down the row dwell or the debounce interval
 */
`timescale 1ns/1ps
`include "keypad_settings.svh"

module scan_timer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     timer_start,
    input  keypad_pkg::timer_mode_e  timer_mode,
    output logic                     timer_done
);
    import keypad_pkg::*;

    localparam int unsigned dwell    = `KEYPAD_SCAN_DWELL;
    localparam int unsigned debounce = `KEYPAD_DEBOUNCE_CYCLES;
    localparam int unsigned max_load = (dwell > debounce) ? dwell : debounce;
    localparam int unsigned cnt_w    = $clog2(max_load + 1);

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0; // Idle
        end else if (timer_start) begin
            cnt <= (timer_mode == T_DEBOUNCE) ? cnt_w'(debounce) : cnt_w'(dwell);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Last count is the N-th cycle after start
    assign timer_done = (cnt == cnt_w'(1));

endmodule

// File: logic/key_scan_fsm.sv
/*
 * Keypad scanner: column synchronizer, row strobe, hex decode and the
 * scan, debounce, held and release state machine
 */
`timescale 1ns/1ps

module key_scan_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     scan_en,
    input  logic [3:0]               keypad_cols,
    output logic [3:0]               keypad_rows,
    input  logic                     timer_done,
    output logic                     timer_start,
    output keypad_pkg::timer_mode_e  timer_mode,
    output logic                     key_push,
    output keypad_pkg::key_event_t   key_event,
    output logic                     key_down
);
    import keypad_pkg::*;

    // Indexed by {row, col}
    localparam logic [3:0] key_map [16] = '{
        4'h1, 4'h2, 4'h3, 4'hC,
        4'h4, 4'h5, 4'h6, 4'hD,
        4'h7, 4'h8, 4'h9, 4'hE,
        4'hA, 4'h0, 4'hB, 4'hF
    };

    scan_state_e state, state_nxt;
    logic [3:0]  cols_meta, cols_sync;
    logic [1:0]  row;
    logic [1:0]  live_col;
    logic        pressed;
    logic        row_advance;
    logic        capture;
    key_event_t  live_event, held_event;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cols_meta <= 4'hF; // Columns idle high
            cols_sync <= 4'hF;
        end else begin
            cols_meta <= keypad_cols;
            cols_sync <= cols_meta;
        end
    end

    always_comb begin
        pressed = ~&cols_sync;
        casez (cols_sync)
            4'b???0: live_col = 2'd0; // Lowest column wins
            4'b??01: live_col = 2'd1;
            4'b?011: live_col = 2'd2;
            default: live_col = 2'd3;
        endcase
        live_event.code = key_map[{row, live_col}];
        live_event.row  = row;
        live_event.col  = live_col;
    end

    always_comb begin
        state_nxt   = state;
        timer_start = 1'b0;
        timer_mode  = T_DWELL;
        key_push    = 1'b0;
        row_advance = 1'b0;
        capture     = 1'b0;
        if (!scan_en) begin
            state_nxt = OFF;
        end else begin
            case (state)
                OFF: begin
                    state_nxt   = SCAN;
                    timer_start = 1'b1;
                end
                SCAN: begin
                    // Columns have settled by the end of the dwell
                    if (timer_done) begin
                        timer_start = 1'b1;
                        if (pressed) begin
                            state_nxt  = DEBOUNCE;
                            timer_mode = T_DEBOUNCE;
                            capture    = 1'b1;
                        end else begin
                            row_advance = 1'b1;
                        end
                    end
                end
                DEBOUNCE: begin
                    if (timer_done) begin
                        if (pressed && live_event.code == held_event.code) begin
                            key_push  = 1'b1;
                            state_nxt = HELD;
                        end else begin
                            state_nxt   = SCAN; // Rescan the same row
                            timer_start = 1'b1;
                        end
                    end
                end
                HELD: begin
                    if (!pressed) begin
                        state_nxt   = RELEASE;
                        timer_start = 1'b1;
                        timer_mode  = T_DEBOUNCE;
                    end
                end
                RELEASE: begin
                    if (pressed) begin
                        state_nxt = HELD;
                    end else if (timer_done) begin
                        state_nxt   = SCAN;
                        timer_start = 1'b1;
                        row_advance = 1'b1;
                    end
                end
                default: state_nxt = OFF;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= OFF;
            row   <= 2'd0;
        end else begin
            state <= state_nxt;
            if (row_advance) begin
                row <= row + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            held_event <= live_event;
        end
    end

    assign keypad_rows = (state == OFF) ? 4'hF : ~(4'b0001 << row);
    assign key_event   = held_event;
    assign key_down    = (state == HELD) || (state == RELEASE);

endmodule

// File: logic/key_event_fifo.sv
/*
 * Key event FIFO, circular buffer with a sticky overflow flag
 */
`timescale 1ns/1ps

module key_event_fifo #(
    parameter int unsigned depth = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  keypad_pkg::key_event_t  push_event,
    input  logic                    pop,
    output keypad_pkg::key_event_t  head_event,
    output logic                    not_empty,
    output logic [2:0]              count,
    output logic                    overflow,
    input  logic                    clear_overflow
);
    import keypad_pkg::*;

    localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

    key_event_t       mem [depth];
    logic [ptr_w-1:0] wr_ptr, rd_ptr;
    logic             full;
    logic             do_push, do_pop;

    assign full      = (count == 3'(depth));
    assign not_empty = (count != 3'd0);
    assign do_pop    = pop && not_empty;
    assign do_push   = push && (!full || do_pop); // Pop frees a slot this cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= 3'd0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + 3'(do_push) - 3'(do_pop);
            if (push && !do_push) begin
                overflow <= 1'b1; // Event dropped
            end else if (clear_overflow) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_event;
        end
    end

    assign head_event = mem[rd_ptr];

endmodule

// File: logic/keypad_axil_regs.sv
/*
 * AXI4-Lite register block: status, key data with pop on read, control
 * and the FIFO interrupt
 */
`timescale 1ns/1ps

module keypad_axil_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  axil_pkg::axil_req_t     axil_req,
    output axil_pkg::axil_rsp_t     axil_rsp,
    input  keypad_pkg::key_event_t  head_event,
    input  logic                    not_empty,
    input  logic [2:0]              count,
    input  logic                    overflow,
    input  logic                    key_down,
    output logic                    fifo_pop,
    output logic                    clear_overflow,
    output logic                    scan_en,
    output logic                    irq
);
    import axil_pkg::*;

    logic        aw_ready, ar_ready;
    logic        b_valid, r_valid;
    axil_resp_e  b_resp, r_resp;
    logic [31:0] r_data;
    logic        irq_en;
    logic        idle;
    logic        wr_known, wr_ctrl;
    logic        rd_known;
    logic [31:0] rd_word;
    logic [31:0] status_word;

    assign idle = !aw_ready && !ar_ready && !b_valid && !r_valid; // One access at a time

    assign status_word = {25'd0, count, 1'b0, key_down, overflow, not_empty};

    always_comb begin
        rd_known = 1'b1;
        rd_word  = '0;
        case (axil_req.araddr)
            REG_STATUS: rd_word = status_word;
            REG_DATA:   rd_word = not_empty ? {23'd0, 1'b1, 4'd0, head_event.code} : '0;
            REG_CTRL:   rd_word = {29'd0, irq_en, 1'b0, scan_en};
            default:    rd_known = 1'b0;
        endcase
    end

    assign wr_known = (axil_req.awaddr == REG_STATUS) || (axil_req.awaddr == REG_DATA) ||
                      (axil_req.awaddr == REG_CTRL);
    assign wr_ctrl  = aw_ready && (axil_req.awaddr == REG_CTRL);

    assign fifo_pop       = ar_ready && (axil_req.araddr == REG_DATA) && not_empty;
    assign clear_overflow = wr_ctrl && axil_req.wdata[1];
    assign irq            = irq_en && not_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_ready <= 1'b0;
            ar_ready <= 1'b0;
            b_valid  <= 1'b0;
            b_resp   <= OKAY;
            r_valid  <= 1'b0;
            r_resp   <= OKAY;
            r_data   <= '0;
            scan_en  <= 1'b0;
            irq_en   <= 1'b0;
        end else begin
            aw_ready <= idle && axil_req.awvalid && axil_req.wvalid;
            // Writes win a tie
            ar_ready <= idle && axil_req.arvalid && !(axil_req.awvalid && axil_req.wvalid);

            if (aw_ready) begin
                b_valid <= 1'b1;
                b_resp  <= wr_known ? OKAY : SLVERR;
                if (wr_ctrl) begin
                    scan_en <= axil_req.wdata[0];
                    irq_en  <= axil_req.wdata[2];
                end
            end else if (b_valid && axil_req.bready) begin
                b_valid <= 1'b0;
            end

            if (ar_ready) begin
                r_valid <= 1'b1;
                r_data  <= rd_word;
                r_resp  <= rd_known ? OKAY : SLVERR;
            end else if (r_valid && axil_req.rready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_comb begin
        axil_rsp.awready = aw_ready;
        axil_rsp.wready  = aw_ready; // Address and data accepted together
        axil_rsp.bresp   = b_resp;
        axil_rsp.bvalid  = b_valid;
        axil_rsp.arready = ar_ready;
        axil_rsp.rdata   = r_data;
        axil_rsp.rresp   = r_resp;
        axil_rsp.rvalid  = r_valid;
    end

endmodule

// File: logic/keypad_ctrl_top.sv
/*
 * Keypad controller top: scan timer, scanner FSM, event FIFO, bus registers
 */
`timescale 1ns/1ps
`include "keypad_settings.svh"

module keypad_ctrl_top (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic [3:0]           keypad_rows,
    input  logic [3:0]           keypad_cols,
    input  axil_pkg::axil_req_t  axil_req,
    output axil_pkg::axil_rsp_t  axil_rsp,
    output logic                 irq
);
    import keypad_pkg::*;

    logic        timer_start, timer_done;
    timer_mode_e timer_mode;
    logic        key_push, key_down;
    key_event_t  key_event, head_event;
    logic        not_empty, overflow;
    logic [2:0]  count;
    logic        fifo_pop, clear_overflow, scan_en;

    scan_timer scan_timer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .timer_start (timer_start),
        .timer_mode  (timer_mode),
        .timer_done  (timer_done)
    );

    key_scan_fsm key_scan_fsm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .scan_en     (scan_en),
        .keypad_cols (keypad_cols),
        .keypad_rows (keypad_rows),
        .timer_done  (timer_done),
        .timer_start (timer_start),
        .timer_mode  (timer_mode),
        .key_push    (key_push),
        .key_event   (key_event),
        .key_down    (key_down)
    );

    key_event_fifo #(
        .depth (`KEYPAD_FIFO_DEPTH)
    ) key_event_fifo_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .push           (key_push),
        .push_event     (key_event),
        .pop            (fifo_pop),
        .head_event     (head_event),
        .not_empty      (not_empty),
        .count          (count),
        .overflow       (overflow),
        .clear_overflow (clear_overflow)
    );

    keypad_axil_regs keypad_axil_regs_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .axil_req       (axil_req),
        .axil_rsp       (axil_rsp),
        .head_event     (head_event),
        .not_empty      (not_empty),
        .count          (count),
        .overflow       (overflow),
        .key_down       (key_down),
        .fifo_pop       (fifo_pop),
        .clear_overflow (clear_overflow),
        .scan_en        (scan_en),
        .irq            (irq)
    );

endmodule

// File: test/keypad_model.sv
/*
 * Behavioral 4x4 key matrix, a closed contact pulls its column low
 * while its row is strobed low. Toggling a contact models bounce
 */
`timescale 1ns/1ps

module keypad_model (
    input  logic [3:0]  rows,
    input  logic [15:0] closed, // Bit row*4+col
    output logic [3:0]  cols
);

    always_comb begin
        cols = 4'hF; // Pull-ups
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (closed[r*4+c] && !rows[r]) begin
                    cols[c] = 1'b0;
                end
            end
        end
    end

endmodule

// File: test/keypad_ctrl_tb.sv
/*
 * Keypad controller testbench, directed tests over AXI4-Lite with a
 * behavioral key matrix
 */
`timescale 1ns/1ps
`include "keypad_settings.svh"

module keypad_ctrl_tb;
    import axil_pkg::*;

    localparam int bus_limit  = 20;
    localparam int poll_limit = 100;
    localparam int debounce   = `KEYPAD_DEBOUNCE_CYCLES;
    localparam int depth      = `KEYPAD_FIFO_DEPTH;

    // Key layout of the reference pad
    localparam logic [3:0] layout [4][4] = '{
        '{4'h1, 4'h2, 4'h3, 4'hC},
        '{4'h4, 4'h5, 4'h6, 4'hD},
        '{4'h7, 4'h8, 4'h9, 4'hE},
        '{4'hA, 4'h0, 4'hB, 4'hF}
    };

    logic        clk;
    logic        rst_n;
    logic [3:0]  keypad_rows;
    logic [3:0]  keypad_cols;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic        irq;
    logic [15:0] closed;
    int          errors   = 0;
    int          timeouts = 0;
    integer      seed     = 32'h6e9e22d0;

    keypad_ctrl_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .keypad_rows (keypad_rows),
        .keypad_cols (keypad_cols),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .irq         (irq)
    );

    keypad_model keypad_model_i (
        .rows   (keypad_rows),
        .closed (closed),
        .cols   (keypad_cols)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic note_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t: no %s within the allowed time", $time, what);
    endtask

    task automatic check_word(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        assert (actual === expected) else begin
            errors++;
            $display("[FAIL] %0t: %s is 0x%08h, expected 0x%08h", $time, what, actual, expected);
        end
    endtask

    task automatic axil_write(input logic [`KEYPAD_AXI_ADDR_W-1:0] addr,
                              input logic [31:0] data, output axil_resp_e resp);
        int n;
        @(negedge clk);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        n = 0;
        while (!(axil_rsp.awready && axil_rsp.wready) && n < bus_limit) begin
            @(negedge clk);
            n++;
        end
        if (!(axil_rsp.awready && axil_rsp.wready)) note_timeout("write handshake");
        axil_req.awvalid = 1'b0; // Address and data stay for the accept cycle
        axil_req.wvalid  = 1'b0;
        n = 0;
        while (!axil_rsp.bvalid && n < bus_limit) begin
            @(negedge clk);
            n++;
        end
        if (!axil_rsp.bvalid) note_timeout("write response");
        resp = axil_rsp.bresp;
    endtask

    task automatic axil_read(input logic [`KEYPAD_AXI_ADDR_W-1:0] addr,
                             output logic [31:0] data, output axil_resp_e resp);
        int n;
        @(negedge clk);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        n = 0;
        while (!axil_rsp.arready && n < bus_limit) begin
            @(negedge clk);
            n++;
        end
        if (!axil_rsp.arready) note_timeout("read address handshake");
        axil_req.arvalid = 1'b0;
        n = 0;
        while (!axil_rsp.rvalid && n < bus_limit) begin
            @(negedge clk);
            n++;
        end
        if (!axil_rsp.rvalid) note_timeout("read data");
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
    endtask

    // Poll STATUS bit 2 until the key state matches
    task automatic wait_key_down(input logic down);
        logic [31:0] status;
        axil_resp_e  resp;
        int          n;
        n = 0;
        axil_read(REG_STATUS, status, resp);
        while (status[2] !== down && n < poll_limit) begin
            axil_read(REG_STATUS, status, resp);
            n++;
        end
        if (status[2] !== down) note_timeout(down ? "debounced press" : "debounced release");
    endtask

    // Returns on the first falling edge of the given row strobe
    task automatic align_to_row(input logic [3:0] prev_rows, input logic [3:0] next_rows);
        int n;
        n = 0;
        @(negedge clk);
        while (keypad_rows !== prev_rows && n < poll_limit) begin
            @(negedge clk);
            n++;
        end
        if (keypad_rows !== prev_rows) note_timeout("strobe on the previous row");
        n = 0;
        while (keypad_rows !== next_rows && n < poll_limit) begin
            @(negedge clk);
            n++;
        end
        if (keypad_rows !== next_rows) note_timeout("strobe on the target row");
    endtask

    task automatic press_key(input int row, input int col);
        @(negedge clk);
        closed[row*4+col] = 1'b1;
        wait_key_down(1'b1);
    endtask

    task automatic release_key(input int row, input int col);
        @(negedge clk);
        closed[row*4+col] = 1'b0;
        wait_key_down(1'b0);
    endtask

    task automatic bounce_key(input int row, input int col);
        int flips;
        int len;
        flips = 2 + ($unsigned($random(seed)) % 6);
        for (int i = 0; i < flips; i++) begin
            @(negedge clk);
            closed[row*4+col] = ~closed[row*4+col];
            len = 1 + ($unsigned($random(seed)) % 16); // Well under the debounce time
            repeat (len) @(negedge clk);
        end
        closed[row*4+col] = 1'b1;
        wait_key_down(1'b1);
    endtask

    task automatic read_key(input int row, input int col);
        logic [31:0] data;
        axil_resp_e  resp;
        axil_read(REG_DATA, data, resp);
        check_word(data, 32'h0000_0100 | 32'(layout[row][col]),
                   $sformatf("DATA for key at row %0d col %0d", row, col));
    endtask

    task automatic read_reg(input logic [`KEYPAD_AXI_ADDR_W-1:0] addr,
                            input logic [31:0] expected, input string what);
        logic [31:0] data;
        axil_resp_e  resp;
        axil_read(addr, data, resp);
        check_word(data, expected, what);
        check_word(32'(resp), 32'(OKAY), {what, " response"});
    endtask

    task automatic verify_reset;
        check_word(32'(keypad_rows), 32'hF, "rows after reset");
        check_word(32'(irq), 32'd0, "irq after reset");
        read_reg(REG_STATUS, 32'd0, "STATUS after reset");
        read_reg(REG_CTRL, 32'd0, "CTRL after reset");
    endtask

    task automatic scan_all_keys;
        axil_resp_e resp;
        axil_write(REG_CTRL, 32'h1, resp);
        check_word(32'(resp), 32'(OKAY), "write response for CTRL");
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                press_key(r, c);
                release_key(r, c);
                read_key(r, c);
                read_reg(REG_DATA, 32'd0, "DATA when drained");
            end
        end
    endtask

    task automatic exercise_debounce;
        align_to_row(4'b1110, 4'b1101);
        closed[5] = 1'b1; // Short glitch on key 5 while its row is strobed
        repeat (debounce / 2) @(negedge clk);
        closed[5] = 1'b0;
        repeat (4 * debounce) @(negedge clk);
        read_reg(REG_STATUS, 32'd0, "STATUS after glitch");
        bounce_key(2, 1);
        release_key(2, 1);
        read_key(2, 1);
        read_reg(REG_DATA, 32'd0, "DATA after bounced press");
        press_key(3, 2);
        repeat (4 * debounce) @(negedge clk);
        read_key(3, 2);
        read_reg(REG_DATA, 32'd0, "DATA while key held");
        release_key(3, 2);
        press_key(3, 2);
        release_key(3, 2);
        read_key(3, 2);
        read_reg(REG_DATA, 32'd0, "DATA after second press");
    endtask

    task automatic fill_past_depth;
        axil_resp_e resp;
        for (int k = 0; k <= depth; k++) begin
            press_key(k / 4, k % 4);
            release_key(k / 4, k % 4);
        end
        read_reg(REG_STATUS, (depth << 4) | 32'h3, "STATUS after overflow");
        for (int k = 0; k < depth; k++) begin
            read_key(k / 4, k % 4);
        end
        read_reg(REG_DATA, 32'd0, "DATA after overflow drain");
        axil_write(REG_CTRL, 32'h3, resp); // Keep scanning, clear overflow
        read_reg(REG_STATUS, 32'd0, "STATUS after overflow clear");
    endtask

    task automatic irq_and_scan_off;
        axil_resp_e resp;
        int         rows_low;
        press_key(1, 1);
        release_key(1, 1);
        check_word(32'(irq), 32'd0, "irq with irq_en clear");
        axil_write(REG_CTRL, 32'h5, resp);
        check_word(32'(irq), 32'd1, "irq with event pending");
        read_key(1, 1);
        check_word(32'(irq), 32'd0, "irq after drain");
        axil_write(REG_CTRL, 32'h0, resp);
        @(negedge clk);
        closed[0] = 1'b1;
        rows_low = 0;
        repeat (4 * debounce) begin
            @(negedge clk);
            if (keypad_rows != 4'hF) rows_low++;
        end
        closed[0] = 1'b0;
        check_word(32'(rows_low), 32'd0, "cycles with a row strobed while scan is off");
        read_reg(REG_STATUS, 32'd0, "STATUS with scan off");
    endtask

    task automatic access_bad_address;
        logic [31:0] data;
        axil_resp_e  resp;
        axil_write(REG_CTRL, 32'h1, resp);
        axil_write(4'hC, 32'hFFFF_FFFF, resp);
        check_word(32'(resp), 32'(SLVERR), "write response at 0xC");
        axil_read(4'hC, data, resp);
        check_word(32'(resp), 32'(SLVERR), "read response at 0xC");
        check_word(data, 32'd0, "read data at 0xC");
        read_reg(REG_CTRL, 32'h1, "CTRL after bad write");
    endtask

    initial begin
        rst_n          = 1'b0;
        closed         = '0;
        axil_req       = '0;
        axil_req.bready = 1'b1; // Responses always accepted
        axil_req.rready = 1'b1;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        verify_reset();
        scan_all_keys();
        exercise_debounce();
        fill_past_depth();
        irq_and_scan_off();
        access_bad_address();
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+logic
logic/keypad_pkg.sv
logic/axil_pkg.sv
logic/scan_timer.sv
logic/key_scan_fsm.sv
logic/key_event_fifo.sv
logic/keypad_axil_regs.sv
logic/keypad_ctrl_top.sv
test/keypad_model.sv
test/keypad_ctrl_tb.sv

// File: Makefile
# Verilator simulation of the keypad controller

LOG := sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module keypad_ctrl_tb -o keypad_sim
	./obj_dir/keypad_sim | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
